//--- hw/data_ram.sv
`timescale 1ns/1ns
`default_nettype none

`include "lsu_cfg.svh"

module data_ram import lsu_pkg::*; (
  input  var logic      clk,
  input  var logic      arst_n,
  input  var logic      accept,
  input  var word_idx_t word_idx,
  input  var word_t     wdata_lanes,
  input  var byte_en_t  byte_en,
  output word_t         rd_word
);

  word_t mem [`LSU_RAM_WORDS];

  // ##########################################################################
  // Lane writes
  // ##########################################################################

  always_ff @(posedge clk) begin
    if (accept) begin
      for (int i = 0; i < 4; i++) begin
        if (byte_en[i]) begin
          mem[word_idx][8*i +: 8] <= wdata_lanes[8*i +: 8];
        end
      end
    end
  end

  // A store reads the word as it was before the write.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_word <= '0;
    end else if (accept) begin
      rd_word <= mem[word_idx]; // Held while the response is stalled.
    end
  end

endmodule

`default_nettype wire

//--- hw/lsu_pkg.sv
`default_nettype none

`include "lsu_cfg.svh"

package lsu_pkg;

  // Byte address as seen on the request port.
  typedef logic [31:0] addr_t;

  typedef logic [31:0] word_t;

  typedef logic [3:0] byte_en_t; // One write enable per byte lane.

  // Byte position of an access inside its word.
  typedef logic [1:0] lane_t;

  typedef logic [1:0] mem_width_t;

  typedef logic [7:0] uart_byte_t;

  // Sized so the whole RAM is reachable and higher address bits alias.
  typedef logic [$clog2(`LSU_RAM_WORDS)-1:0] word_idx_t;

endpackage

`default_nettype wire

//--- hw/lsu_response.sv
`timescale 1ns/1ns
`default_nettype none

`include "lsu_cfg.svh"

module lsu_response import lsu_pkg::*; (
  input  var logic       clk,
  input  var logic       arst_n,
  input  var logic       req_valid,
  input  var logic       req_is_store,
  input  var logic       req_is_load_unsigned,
  input  var mem_width_t req_width,
  input  var lane_t      offset,
  input  var logic       uart_sel,
  input  var logic       fifo_full,
  input  var word_t      rd_word,
  output logic           accept,
  output logic           req_ready,
  output logic           rsp_valid,
  input  var logic       rsp_ready,
  output word_t          rsp_rdata
);

  mem_width_t width_q;
  lane_t      offset_q;
  logic       unsigned_q;
  logic       zero_q; // Stores and UART loads answer with zero.
  word_t      lane_word;

  // ##########################################################################
  // Acceptance
  // ##########################################################################

  // The response slot frees up in the same cycle it is drained.
  assign req_ready = (!rsp_valid || rsp_ready) && !(req_is_store && uart_sel && fifo_full);
  assign accept    = req_valid && req_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rsp_valid <= 1'b0;
    end else if (accept) begin
      rsp_valid <= 1'b1;
    end else if (rsp_ready) begin
      rsp_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      width_q    <= req_width;
      offset_q   <= offset;
      unsigned_q <= req_is_load_unsigned;
      zero_q     <= req_is_store || uart_sel;
    end
  end

  // ##########################################################################
  // Load extraction
  // ##########################################################################

  assign lane_word = rd_word >> {offset_q, 3'b000};

  always_comb begin
    rsp_rdata = '0;
    if (!zero_q) begin
      case (width_q)
        `MEM_BYTE: rsp_rdata = {{24{lane_word[7] && !unsigned_q}}, lane_word[7:0]};
        `MEM_HALF: rsp_rdata = {{16{lane_word[15] && !unsigned_q}}, lane_word[15:0]};
        `MEM_WORD: rsp_rdata = rd_word;
        default:   rsp_rdata = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/lsu_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "lsu_cfg.svh"

module lsu_top import lsu_pkg::*; (
  input  var logic       clk,
  input  var logic       arst_n,
  input  var logic       req_valid,
  output logic           req_ready,
  input  var logic       req_is_store,
  input  var logic       req_is_load_unsigned,
  input  var addr_t      req_addr,
  input  var mem_width_t req_width,
  input  var word_t      req_wdata,
  output logic           rsp_valid,
  input  var logic       rsp_ready,
  output word_t          rsp_rdata,
  output logic           uart_valid,
  input  var logic       uart_ready,
  output uart_byte_t     uart_data
);

  word_idx_t  word_idx;
  lane_t      offset;
  word_t      wdata_lanes;
  byte_en_t   byte_en;
  uart_byte_t uart_byte;
  logic       uart_sel;
  logic       accept;
  logic       fifo_full;
  logic       fifo_push;
  word_t      rd_word;

  assign fifo_push = accept && uart_sel && req_is_store; // Only stores reach the UART.

  mem_write_align u_align (
    .req_is_store (req_is_store),
    .req_addr     (req_addr),
    .req_width    (req_width),
    .req_wdata    (req_wdata),
    .word_idx     (word_idx),
    .offset       (offset),
    .wdata_lanes  (wdata_lanes),
    .byte_en      (byte_en),
    .uart_byte    (uart_byte),
    .uart_sel     (uart_sel)
  );

  data_ram u_ram (
    .clk         (clk),
    .arst_n      (arst_n),
    .accept      (accept),
    .word_idx    (word_idx),
    .wdata_lanes (wdata_lanes),
    .byte_en     (byte_en),
    .rd_word     (rd_word)
  );

  uart_tx_fifo u_uart_fifo (
    .clk        (clk),
    .arst_n     (arst_n),
    .push       (fifo_push),
    .push_byte  (uart_byte),
    .fifo_full  (fifo_full),
    .uart_valid (uart_valid),
    .uart_ready (uart_ready),
    .uart_data  (uart_data)
  );

  lsu_response u_rsp (
    .clk                  (clk),
    .arst_n               (arst_n),
    .req_valid            (req_valid),
    .req_is_store         (req_is_store),
    .req_is_load_unsigned (req_is_load_unsigned),
    .req_width            (req_width),
    .offset               (offset),
    .uart_sel             (uart_sel),
    .fifo_full            (fifo_full),
    .rd_word              (rd_word),
    .accept               (accept),
    .req_ready            (req_ready),
    .rsp_valid            (rsp_valid),
    .rsp_ready            (rsp_ready),
    .rsp_rdata            (rsp_rdata)
  );

endmodule

`default_nettype wire

//--- hw/mem_write_align.sv
`timescale 1ns/1ns
`default_nettype none

`include "lsu_cfg.svh"

module mem_write_align import lsu_pkg::*; (
  input  var logic       req_is_store,
  input  var addr_t      req_addr,
  input  var mem_width_t req_width,
  input  var word_t      req_wdata,
  output word_idx_t      word_idx,
  output lane_t          offset,
  output word_t          wdata_lanes,
  output byte_en_t       byte_en,
  output uart_byte_t     uart_byte,
  output logic           uart_sel
);

  assign word_idx = req_addr[2 +: $bits(word_idx_t)];
  assign offset   = req_addr[1:0];

  assign uart_sel  = (req_addr == `LSU_UART_ADDR);
  assign uart_byte = req_wdata[7:0]; // The UART address is word aligned.

  // Lanes shifted past byte 3 fall off the top of the word.
  always_comb begin
    wdata_lanes = '0;
    byte_en     = '0;
    if (req_is_store) begin
      case (req_width)
        `MEM_BYTE: begin
          wdata_lanes = word_t'(req_wdata[7:0]) << {offset, 3'b000};
          byte_en     = byte_en_t'(4'b0001 << offset);
        end
        `MEM_HALF: begin
          wdata_lanes = word_t'(req_wdata[15:0]) << {offset, 3'b000};
          byte_en     = byte_en_t'(4'b0011 << offset);
        end
        `MEM_WORD: begin
          wdata_lanes = req_wdata;
          byte_en     = 4'b1111;
        end
        default: begin
          wdata_lanes = '0;
          byte_en     = '0;
        end
      endcase
    end
    if (uart_sel) begin
      byte_en = '0; // The UART byte must not land in the RAM.
    end
  end

endmodule

`default_nettype wire

//--- hw/uart_tx_fifo.sv
`timescale 1ns/1ns
`default_nettype none

`include "lsu_cfg.svh"

module uart_tx_fifo import lsu_pkg::*; (
  input  var logic       clk,
  input  var logic       arst_n,
  input  var logic       push,
  input  var uart_byte_t push_byte,
  output logic           fifo_full,
  output logic           uart_valid,
  input  var logic       uart_ready,
  output uart_byte_t     uart_data
);

  localparam int DEPTH = `LSU_UART_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  uart_byte_t       fifo_mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             pop;

  assign pop        = uart_valid && uart_ready;
  assign uart_valid = (count != '0);
  assign uart_data  = fifo_mem[rd_ptr];
  assign fifo_full  = (count == CNT_W'(DEPTH));

  always_ff @(posedge clk) begin
    if (push) begin
      fifo_mem[wr_ptr] <= push_byte;
    end
  end

  // Pointers wrap at DEPTH so the depth need not be a power of two.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(push) - CNT_W'(pop);
    end
  end

endmodule

`default_nettype wire

//--- include/lsu_cfg.svh
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// ##########################################################################
// Memory map and sizes
// ##########################################################################

// Data RAM depth in 32-bit words.
`define LSU_RAM_WORDS 256
`define LSU_UART_FIFO_DEPTH 4
`define LSU_UART_ADDR 32'h0000_1000 // Stores here go to the UART byte queue.

// ##########################################################################
// Access width codes
// ##########################################################################

`define MEM_BYTE 2'd0
`define MEM_HALF 2'd1
`define MEM_WORD 2'd2 // Code 3 is no access and enables no lanes.

`endif

//--- project.f
+incdir+include
hw/lsu_pkg.sv
hw/mem_write_align.sv
hw/data_ram.sv
hw/uart_tx_fifo.sv
hw/lsu_response.sv
hw/lsu_top.sv
verif/lsu_assertions.sv
verif/lsu_checker.sv
verif/lsu_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the LSU testbench with Verilator, runs it and checks the log.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -f project.f --top-module lsu_tb -o lsu_sim; then
  echo "Verilator build failed."
  exit 1
fi

./obj_dir/lsu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status."
  exit 1
fi

if grep -qx "test passed" "$LOG"; then
  echo "Simulation passed."
  exit 0
else
  echo "Simulation failed, see $LOG."
  exit 1
fi

//--- verif/lsu_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module lsu_assertions (
  input var logic       clk,
  input var logic       arst_n,
  input var logic       rsp_valid,
  input var logic       rsp_ready,
  input var logic [31:0] rsp_rdata,
  input var logic       uart_valid,
  input var logic       uart_ready,
  input var logic [7:0] uart_data
);

  int assert_errors = 0;

  // A stalled response must wait unchanged for the consumer.
  rsp_stall_stable: assert property (
    @(posedge clk) disable iff (!arst_n)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata)
  ) else begin
    $error("Response changed while stalled.");
    assert_errors++;
  end

  uart_stall_stable: assert property (
    @(posedge clk) disable iff (!arst_n)
    uart_valid && !uart_ready |=> uart_valid && $stable(uart_data)
  ) else begin
    $error("UART byte changed while stalled.");
    assert_errors++;
  end

  idle_in_reset: assert property (
    @(posedge clk) !arst_n |-> !rsp_valid && !uart_valid
  ) else begin
    $error("Valid output high during reset.");
    assert_errors++;
  end

endmodule

bind lsu_top lsu_assertions u_assertions (
  .clk        (clk),
  .arst_n     (arst_n),
  .rsp_valid  (rsp_valid),
  .rsp_ready  (rsp_ready),
  .rsp_rdata  (rsp_rdata),
  .uart_valid (uart_valid),
  .uart_ready (uart_ready),
  .uart_data  (uart_data)
);

`default_nettype wire

//--- verif/lsu_checker.sv
`timescale 1ns/1ns
`default_nettype none

`include "lsu_cfg.svh"

module lsu_checker import lsu_pkg::*; (
  input var logic       clk,
  input var logic       arst_n,
  input var logic       req_valid,
  input var logic       req_ready,
  input var logic       req_is_store,
  input var addr_t      req_addr,
  input var word_t      req_wdata,
  input var word_t      expected_rdata, // Travels with the request fields.
  input var logic       rsp_valid,
  input var logic       rsp_ready,
  input var word_t      rsp_rdata,
  input var logic       uart_valid,
  input var logic       uart_ready,
  input var uart_byte_t uart_data,
  output int            rsp_errors,
  output int            uart_errors,
  output int            handshake_errors,
  output int            rsp_count,
  output logic          idle
);

  word_t      rsp_queue [$];
  uart_byte_t uart_queue [$];

  // Handshakes are sampled on the falling edge and complete on the next rising edge.
  always @(negedge clk) begin
    word_t      want_word;
    uart_byte_t want_byte;
    logic       want_ready;
    if (arst_n) begin
      // The queues hold what the response stage and the UART FIFO hold right now.
      want_ready = (rsp_queue.size() == 0 || rsp_ready) &&
                   !(req_is_store && req_addr == `LSU_UART_ADDR &&
                     uart_queue.size() == `LSU_UART_FIFO_DEPTH);
      if (rsp_valid !== (rsp_queue.size() != 0)) begin
        $display("[ERROR] %0t ns: rsp_valid %b with %0d responses outstanding", $time,
                 rsp_valid, rsp_queue.size());
        handshake_errors++;
      end
      if (req_ready !== want_ready) begin
        $display("[ERROR] %0t ns: req_ready %b, expected %b", $time, req_ready, want_ready);
        handshake_errors++;
      end
      if (rsp_valid && rsp_ready) begin
        rsp_count++;
        if (rsp_queue.size() == 0) begin
          $display("Response at %0t ns arrived with no request outstanding.", $time);
          rsp_errors++;
        end else begin
          want_word = rsp_queue.pop_front();
          if (rsp_rdata !== want_word) begin
            $display("[ERROR] %0t ns: response data %h, expected %h", $time, rsp_rdata,
                     want_word);
            rsp_errors++;
          end
        end
      end
      if (uart_valid && uart_ready) begin
        if (uart_queue.size() == 0) begin
          $display("UART byte at %0t ns was sent with no store to the UART.", $time);
          uart_errors++;
        end else begin
          want_byte = uart_queue.pop_front();
          if (uart_data !== want_byte) begin
            $display("[ERROR] %0t ns: UART byte %h, expected %h", $time, uart_data, want_byte);
            uart_errors++;
          end
        end
      end
      if (req_valid && req_ready) begin
        rsp_queue.push_back(expected_rdata);
        if (req_is_store && req_addr == `LSU_UART_ADDR) begin
          uart_queue.push_back(req_wdata[7:0]); // Only the low byte leaves.
        end
      end
    end
    idle = (rsp_queue.size() == 0) && (uart_queue.size() == 0);
  end

endmodule

`default_nettype wire

//--- verif/lsu_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "lsu_cfg.svh"

module lsu_tb import lsu_pkg::*; ();

  logic       clk;
  logic       arst_n;
  logic       req_valid;
  logic       req_ready;
  logic       req_is_store;
  logic       req_is_load_unsigned;
  addr_t      req_addr;
  mem_width_t req_width;
  word_t      req_wdata;
  word_t      expected_rdata;
  logic       rsp_valid;
  logic       rsp_ready = 1'b0;
  word_t      rsp_rdata;
  logic       uart_valid;
  logic       uart_ready = 1'b0;
  uart_byte_t uart_data;
  logic       uart_hold;
  logic       idle;
  int         rsp_errors;
  int         uart_errors;
  int         handshake_errors;
  int         rsp_count;
  int         other_errors;
  int         cycles = 0;
  int         cycle_limit;

  // Stimulus table, one entry per request.
  logic       row_store [$];
  logic       row_unsigned [$];
  mem_width_t row_width [$];
  addr_t      row_addr [$];
  word_t      row_wdata [$];
  word_t      row_expected [$];
  logic       row_hold [$]; // Starts a UART stall at this row.

  lsu_top DUT (.*);

  lsu_checker u_checker (.*);

  // ##########################################################################
  // Clock, random back-pressure and timeout
  // ##########################################################################

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    rsp_ready  <= ($urandom % 100) < 70;
    uart_ready <= !uart_hold && (($urandom % 100) < 70);
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles.", cycle_limit);
      $display("test failed");
      $finish;
    end
  end

  // ##########################################################################
  // Table and row application
  // ##########################################################################

  task automatic add_row(input logic st, input logic uns, input mem_width_t w, input addr_t a,
                         input word_t d, input word_t exp, input logic hold);
    row_store.push_back(st);
    row_unsigned.push_back(uns);
    row_width.push_back(w);
    row_addr.push_back(a);
    row_wdata.push_back(d);
    row_expected.push_back(exp);
    row_hold.push_back(hold);
  endtask

  task automatic build_table();
    add_row(1'b1, 1'b0, `MEM_WORD, 32'h0000_0100, 32'h1234_5678, 32'h0000_0000, 1'b0);
    add_row(1'b0, 1'b0, `MEM_WORD, 32'h0000_0100, 32'h0000_0000, 32'h1234_5678, 1'b0);
    add_row(1'b1, 1'b0, `MEM_BYTE, 32'h0000_0104, 32'hFFFF_FF11, 32'h0000_0000, 1'b0);
    add_row(1'b1, 1'b0, `MEM_BYTE, 32'h0000_0105, 32'h0000_0022, 32'h0000_0000, 1'b0);
    add_row(1'b1, 1'b0, `MEM_HALF, 32'h0000_0106, 32'hAAAA_3344, 32'h0000_0000, 1'b0);
    add_row(1'b0, 1'b0, `MEM_WORD, 32'h0000_0104, 32'h0000_0000, 32'h3344_2211, 1'b0);
    add_row(1'b1, 1'b0, `MEM_WORD, 32'h0000_0108, 32'hFFFF_FFFF, 32'h0000_0000, 1'b0);
    add_row(1'b1, 1'b0, `MEM_HALF, 32'h0000_0108, 32'h1234_BEEF, 32'h0000_0000, 1'b0);
    add_row(1'b1, 1'b0, `MEM_BYTE, 32'h0000_010B, 32'hAAAA_AA00, 32'h0000_0000, 1'b0);
    add_row(1'b0, 1'b0, `MEM_WORD, 32'h0000_0108, 32'h0000_0000, 32'h00FF_BEEF, 1'b0);
    add_row(1'b1, 1'b0, `MEM_BYTE, 32'h0000_010A, 32'hFFFF_FF5A, 32'h0000_0000, 1'b0);
    add_row(1'b0, 1'b0, `MEM_WORD, 32'h0000_0108, 32'h0000_0000, 32'h005A_BEEF, 1'b0);
    add_row(1'b1, 1'b0, `MEM_WORD, 32'h0000_010C, 32'h8F7F_F001, 32'h0000_0000, 1'b0);
    add_row(1'b0, 1'b0, `MEM_BYTE, 32'h0000_010C, 32'h0000_0000, 32'h0000_0001, 1'b0);
    add_row(1'b0, 1'b0, `MEM_BYTE, 32'h0000_010D, 32'h0000_0000, 32'hFFFF_FFF0, 1'b0);
    add_row(1'b0, 1'b1, `MEM_BYTE, 32'h0000_010D, 32'h0000_0000, 32'h0000_00F0, 1'b0);
    add_row(1'b0, 1'b0, `MEM_BYTE, 32'h0000_010E, 32'h0000_0000, 32'h0000_007F, 1'b0);
    add_row(1'b0, 1'b0, `MEM_BYTE, 32'h0000_010F, 32'h0000_0000, 32'hFFFF_FF8F, 1'b0);
    add_row(1'b0, 1'b1, `MEM_BYTE, 32'h0000_010F, 32'h0000_0000, 32'h0000_008F, 1'b0);
    add_row(1'b0, 1'b0, `MEM_HALF, 32'h0000_010C, 32'h0000_0000, 32'hFFFF_F001, 1'b0);
    add_row(1'b0, 1'b1, `MEM_HALF, 32'h0000_010C, 32'h0000_0000, 32'h0000_F001, 1'b0);
    add_row(1'b0, 1'b0, `MEM_HALF, 32'h0000_010D, 32'h0000_0000, 32'h0000_7FF0, 1'b0);
    add_row(1'b0, 1'b0, `MEM_HALF, 32'h0000_010E, 32'h0000_0000, 32'hFFFF_8F7F, 1'b0);
    add_row(1'b0, 1'b1, `MEM_HALF, 32'h0000_010E, 32'h0000_0000, 32'h0000_8F7F, 1'b0);
    add_row(1'b0, 1'b0, `MEM_HALF, 32'h0000_010F, 32'h0000_0000, 32'h0000_008F, 1'b0);
    add_row(1'b0, 1'b0, `MEM_HALF, 32'h0000_0106, 32'h0000_0000, 32'h0000_3344, 1'b0);
    // Word 0 shares its RAM index with the UART address.
    add_row(1'b1, 1'b0, `MEM_WORD, 32'h0000_0000, 32'hCAFE_F00D, 32'h0000_0000, 1'b0);
    add_row(1'b1, 1'b0, `MEM_WORD, `LSU_UART_ADDR, 32'hFFFF_FF41, 32'h0000_0000, 1'b0);
    add_row(1'b1, 1'b0, `MEM_WORD, `LSU_UART_ADDR, 32'h0000_0042, 32'h0000_0000, 1'b0);
    add_row(1'b0, 1'b0, `MEM_WORD, `LSU_UART_ADDR, 32'h0000_0000, 32'h0000_0000, 1'b0);
    for (int i = 0; i < 6; i++) begin
      add_row(1'b1, 1'b0, `MEM_WORD, `LSU_UART_ADDR, 32'h50 + i, 32'h0000_0000, i == 0);
    end
    add_row(1'b0, 1'b0, `MEM_WORD, 32'h0000_0000, 32'h0000_0000, 32'hCAFE_F00D, 1'b0);
    add_row(1'b0, 1'b0, `MEM_BYTE, 32'h0000_0003, 32'h0000_0000, 32'hFFFF_FFCA, 1'b0);
  endtask

  // Drives one row and returns once it will be accepted on the next rising edge.
  task automatic apply_row(input int r);
    int waited;
    waited = 0;
    @(posedge clk);
    req_valid            <= 1'b1;
    req_is_store         <= row_store[r];
    req_is_load_unsigned <= row_unsigned[r];
    req_width            <= row_width[r];
    req_addr             <= row_addr[r];
    req_wdata            <= row_wdata[r];
    expected_rdata       <= row_expected[r];
    if (row_hold[r]) begin
      uart_hold <= 1'b1;
    end
    @(negedge clk);
    while (!req_ready) begin
      waited++;
      if (waited == 12) begin
        uart_hold <= 1'b0; // Lets the full FIFO drain.
      end
      @(negedge clk);
    end
  endtask

  initial begin
    void'($urandom(63));
    build_table();
    cycle_limit          = 40 * row_store.size() + 100;
    other_errors         = 0;
    arst_n               = 1'b0;
    req_valid            = 1'b0;
    req_is_store         = 1'b0;
    req_is_load_unsigned = 1'b0;
    req_width            = `MEM_WORD;
    req_addr             = '0;
    req_wdata            = '0;
    expected_rdata       = '0;
    uart_hold            = 1'b0;
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;
    for (int r = 0; r < row_store.size(); r++) begin
      apply_row(r);
    end
    @(posedge clk);
    req_valid <= 1'b0;
    uart_hold <= 1'b0;
    @(posedge clk);
    while (!idle || uart_valid) begin
      @(posedge clk);
    end
    if (rsp_count != row_store.size()) begin
      $display("Got %0d responses for %0d requests.", rsp_count, row_store.size());
      other_errors++;
    end
    $display("Errors: %0d response, %0d UART, %0d handshake, %0d assertion, %0d other",
             rsp_errors, uart_errors, handshake_errors, DUT.u_assertions.assert_errors,
             other_errors);
    if (rsp_errors + uart_errors + handshake_errors + DUT.u_assertions.assert_errors +
        other_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
